/* Makefile */
TOP := ula_video_tb
SIM := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test: $(SIM)
	./$(SIM)

$(SIM): files.f design/*.sv bench/*.sv bench/*.svh
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

/* bench/ula_video_checks.svh */
`ifndef ULA_VIDEO_CHECKS_SVH
`define ULA_VIDEO_CHECKS_SVH

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Run control and compare tasks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
endtask

task automatic check_rgb(input string name, input ula_video_pkg::rgb_t got,
                         input ula_video_pkg::rgb_t exp);
    n_checks = n_checks + 1;
    if (got !== exp) begin
        stop_run($sformatf("mismatch at %0t: %s is %h, expected %h (h %0d, v %0d, frame %0d)",
                           $time, name, got, exp, tb_h, tb_v, tb_frame));
    end
endtask

task automatic check_level(input string name, input logic got, input logic exp);
    n_checks = n_checks + 1;
    if (got !== exp) begin
        stop_run($sformatf("mismatch at %0t: %s is %b, expected %b (h %0d, v %0d)",
                           $time, name, got, exp, tb_h, tb_v));
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    n_checks = n_checks + 1;
    if (got != exp) begin
        stop_run($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                           $time, name, got, exp));
    end
endtask

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Screen layout and expected colour
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Third, row within char, char row, column
function automatic ula_video_pkg::vram_addr_t bitmap_addr(input logic [7:0] y,
                                                          input logic [4:0] c);
    return {y[7:6], y[2:0], y[5:3], c};
endfunction

function automatic ula_video_pkg::vram_addr_t attr_addr(input logic [7:0] y,
                                                        input logic [4:0] c);
    return {3'b110, y[7:3], c};     // One attribute per 8x8 cell
endfunction

function automatic ula_video_pkg::rgb_t expected_rgb(input int h, input int v,
                                                     input logic [2:0] b, input int f);
    int                   px;
    int                   py;
    int                   col;
    logic [2:0]           sel;
    logic [7:0]           bits;
    ula_video_pkg::attr_t attr;
    logic [2:0]           ink;
    logic [2:0]           paper;
    if (h < ula_video_pkg::h_disp_start || h >= ula_video_pkg::h_disp_end ||
        v < ula_video_pkg::v_disp_start || v >= ula_video_pkg::v_disp_end) begin
        return '0;                                      // Blanking
    end
    if (h < ula_video_pkg::h_scr_start || h >= ula_video_pkg::h_scr_end ||
        v < ula_video_pkg::v_scr_start || v >= ula_video_pkg::v_scr_end) begin
        return ula_video_pkg::palette({1'b0, b});       // Border never bright
    end
    px    = (h - ula_video_pkg::h_scr_start) / 2;       // Pixels are doubled
    py    = (v - ula_video_pkg::v_scr_start) / 2;       // And so are lines
    col   = px / 8;
    sel   = 3'd7 - px[2:0];                             // MSB is leftmost
    bits  = shadow[bitmap_addr(py[7:0], col[4:0])];
    attr  = ula_video_pkg::attr_t'(shadow[attr_addr(py[7:0], col[4:0])]);
    ink   = attr.ink;
    paper = attr.paper;
    if (attr.flash && f[flash_log2]) begin
        ink   = attr.paper;                             // Flash phase swaps colours
        paper = attr.ink;
    end
    return ula_video_pkg::palette({attr.bright, bits[sel] ? ink : paper});
endfunction

`endif

/* bench/ula_video_tb.sv */
`timescale 1ns/1ps

module ula_video_tb;

    localparam int flash_log2     = 1;      // Two frames normal, two swapped
    localparam int run_frames     = 4;
    localparam int table_len      = 8;
    localparam int vram_depth     = 8192;
    localparam int frame_clocks   = ula_video_pkg::h_total * ula_video_pkg::v_total;
    localparam int timeout_cycles = run_frames * frame_clocks * 11 / 10;  // 10 percent slack

    typedef struct packed {
        logic [4:0] col;        // Cell column
        logic [7:0] row;        // Screen pixel row 0..191
        logic [7:0] bits;
        logic [7:0] attr;       // Flash, bright, paper, ink
        logic [2:0] border;     // Border for the frame with this index
    } stim_t;

    // DUT ports
    logic                      clk_pix = 1'b0;
    logic                      arst_n;
    logic [2:0]                border;
    logic                      cpu_we;
    ula_video_pkg::vram_addr_t cpu_addr;
    logic [7:0]                cpu_data;
    logic [3:0]                vga_r;
    logic [3:0]                vga_g;
    logic [3:0]                vga_b;
    logic                      vga_hs;
    logic                      vga_vs;
    logic                      vs_nintr;

    int                  tb_h;          // Raster model, same values as DUT counters
    int                  tb_v;
    int                  tb_frame;
    int                  cycles;
    int                  n_checks;
    int                  hs_low;        // Measured periods
    int                  vs_lines;
    int                  nintr_low;
    int                  seed;
    logic                load_done;
    ula_video_pkg::rgb_t exp_rgb;
    logic [7:0]          shadow [vram_depth];   // Expected VRAM contents

    stim_t stim_table [table_len] = '{
        '{5'd0,  8'd0,   8'hAA, 8'h47, 3'd1},  // Top left, bright white on black
        '{5'd31, 8'd191, 8'h0F, 8'h8E, 3'd2},  // Bottom right, flashing
        '{5'd5,  8'd64,  8'hF0, 8'hC5, 3'd5},  // Flash and bright
        '{5'd17, 8'd130, 8'h81, 8'h40, 3'd7},  // Bright black stays 000
        '{5'd9,  8'd7,   8'h3C, 8'h3A, 3'd0},
        '{5'd20, 8'd100, 8'hFF, 8'hB8, 3'd3},  // Solid ink, flash swaps to paper
        '{5'd12, 8'd150, 8'h00, 8'h60, 3'd4},  // Solid paper
        '{5'd26, 8'd45,  8'h55, 8'h1B, 3'd6}   // Ink equals paper
    };

    `include "ula_video_checks.svh"

    ula_video #(.FLASH_LOG2(flash_log2)) ula_video_inst (
        .clk_pix, .arst_n, .border, .cpu_we, .cpu_addr, .cpu_data,
        .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs, .vs_nintr
    );

    always #4 clk_pix = ~clk_pix;           // 8 ns period

    function automatic logic [2:0] border_for_frame(input int f);
        logic [2:0] idx;
        idx = 3'(f % table_len);
        return stim_table[idx].border;
    endfunction

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster model and watchdog
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk_pix) begin
        if (!arst_n) begin
            tb_h     <= 0;                  // Held at 0 until first edge after release
            tb_v     <= 0;
            tb_frame <= 0;
        end else if (tb_h == ula_video_pkg::h_total - 1) begin
            tb_h <= 0;
            if (tb_v == ula_video_pkg::v_total - 1) begin
                tb_v     <= 0;
                tb_frame <= tb_frame + 1;
            end else begin
                tb_v <= tb_v + 1;
            end
        end else begin
            tb_h <= tb_h + 1;
        end
    end

    always @(posedge clk_pix) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            stop_run($sformatf("timeout: run did not end within %0d clock cycles",
                               timeout_cycles));
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output checks on the falling edge
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk_pix) begin
        exp_rgb = expected_rgb(tb_h, tb_v, border, tb_frame);
        check_rgb("vga_rgb", {vga_r, vga_g, vga_b}, exp_rgb);
        check_level("vga_hs", vga_hs, tb_h >= ula_video_pkg::h_sync);
        check_level("vga_vs", vga_vs, tb_v >= ula_video_pkg::v_sync);
        check_level("vs_nintr", vs_nintr, !(tb_v == ula_video_pkg::v_disp_start
                                            && tb_h < ula_video_pkg::h_disp_start));
        if (arst_n) begin                   // Periods only count after release
            if (tb_v == ula_video_pkg::v_scr_start && tb_h == 0 && !load_done) begin
                stop_run("VRAM load was still running when the screen area began");
            end
            if (!vga_hs) hs_low = hs_low + 1;
            if (!vga_vs && tb_h == 0) vs_lines = vs_lines + 1;
            if (!vs_nintr) nintr_low = nintr_low + 1;
            if (tb_h == ula_video_pkg::h_total - 1) begin
                check_count("vga_hs low clocks per line", hs_low, ula_video_pkg::h_sync);
                hs_low = 0;
                if (tb_v == ula_video_pkg::v_total - 1) begin   // Frame done
                    check_count("vga_vs low lines per frame", vs_lines, ula_video_pkg::v_sync);
                    check_count("vs_nintr low clocks per frame", nintr_low,
                                ula_video_pkg::h_disp_start);
                    vs_lines  = 0;
                    nintr_low = 0;
                end
            end
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // VRAM load through the CPU port
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Starts in reset and ends near line 10, well before the first fetch
    initial begin : vram_load
        int                        a;
        ula_video_pkg::vram_addr_t addr;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_data  = '0;
        load_done = 1'b0;
        seed      = 93;
        for (a = 0; a < vram_depth; a++) begin
            addr         = ula_video_pkg::vram_addr_t'(a);
            shadow[addr] = 8'($random(seed));          // Background cells
        end
        for (a = 0; a < table_len; a++) begin          // Table cells win over random
            shadow[bitmap_addr(stim_table[a].row, stim_table[a].col)] = stim_table[a].bits;
            shadow[attr_addr(stim_table[a].row, stim_table[a].col)]   = stim_table[a].attr;
        end
        for (a = 0; a < vram_depth; a++) begin
            addr = ula_video_pkg::vram_addr_t'(a);
            @(posedge clk_pix);
            cpu_we   <= 1'b1;
            cpu_addr <= addr;
            cpu_data <= shadow[addr];
        end
        @(posedge clk_pix);
        cpu_we    <= 1'b0;
        load_done = 1'b1;
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset, border per frame and end of run
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        arst_n = 1'b0;
        border = border_for_frame(0);
        repeat (8) @(posedge clk_pix);
        arst_n <= 1'b1;
        while (tb_frame < run_frames) begin
            @(posedge clk_pix);
            // New border on the same edge as the DUT frame wrap
            if (tb_h == ula_video_pkg::h_total - 1 && tb_v == ula_video_pkg::v_total - 1) begin
                border <= border_for_frame(tb_frame + 1);
            end
        end
        if (n_checks == 0) begin
            stop_run("no output checks were made");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* design/pixel_render.sv */
`timescale 1ns/1ps

module pixel_render #(
    parameter int FLASH_LOG2 = 4        // Below zero disables flashing
) (
    input  ula_video_pkg::hcount_t    hcount,
    input  logic                      disp_en,
    input  logic                      scr_en,
    input  logic                      flash_phase,
    input  logic [2:0]                border,
    input  ula_video_pkg::vram_byte_u cell_bits,
    input  ula_video_pkg::vram_byte_u cell_attr,
    output logic [3:0]                vga_r,
    output logic [3:0]                vga_g,
    output logic [3:0]                vga_b
);

    localparam bit flash_en = (FLASH_LOG2 >= 0);

    ula_video_pkg::attr_t   attr;
    logic [2:0]             bit_sel;
    logic                   pix_bit;    // Current bitmap pixel
    logic                   inverted;   // Ink and paper swapped
    logic [2:0]             ink;
    logic [2:0]             paper;
    ula_video_pkg::cindex_t cindex;
    ula_video_pkg::rgb_t    pix_rgb;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel select
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MSB first; hcount[0] is ignored so each pixel lasts two clocks
    assign bit_sel = 3'd7 - hcount[3:1];
    assign pix_bit = cell_bits.bits[bit_sel];

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Attribute decode and flash
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign attr     = cell_attr.attr;
    assign inverted = flash_en && attr.flash && flash_phase;
    assign ink      = inverted ? attr.paper : attr.ink;
    assign paper    = inverted ? attr.ink   : attr.paper;

    // Screen pixels carry bright, the border never does
    always_comb begin
        if (scr_en) begin
            cindex = pix_bit ? {attr.bright, ink} : {attr.bright, paper};
        end else begin
            cindex = {1'b0, border};
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Palette and blanking
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign pix_rgb = ula_video_pkg::palette(cindex);

    assign vga_r = disp_en ? pix_rgb[11:8] : 4'h0;  // Black in blanking
    assign vga_g = disp_en ? pix_rgb[7:4]  : 4'h0;
    assign vga_b = disp_en ? pix_rgb[3:0]  : 4'h0;

endmodule

/* design/screen_fetch.sv */
`timescale 1ns/1ps

module screen_fetch (
    input  logic                      clk_pix,
    input  logic                      arst_n,
    input  ula_video_pkg::hcount_t    hcount,
    input  ula_video_pkg::vcount_t    vcount,
    output ula_video_pkg::vram_addr_t vram_addr,
    input  logic [7:0]                vram_rdata,   // One clock after vram_addr
    output ula_video_pkg::vram_byte_u cell_bits,    // Working bitmap byte
    output ula_video_pkg::vram_byte_u cell_attr     // Working attribute byte
);

    // Fetch runs one 16 clock cell ahead of the pixels being drawn
    localparam ula_video_pkg::hcount_t x_origin = ula_video_pkg::hcount_t'(
        ula_video_pkg::h_scr_start - 16);
    localparam ula_video_pkg::vcount_t y_origin = ula_video_pkg::vcount_t'(
        ula_video_pkg::v_scr_start);

    ula_video_pkg::hcount_t x_off;          // Clocks from prefetch origin
    ula_video_pkg::vcount_t y_off;          // Lines from screen top
    logic [4:0]             col;            // Cell column 0..31
    logic [7:0]             py;             // Spectrum pixel row

    ula_video_pkg::vram_byte_u bits_pre;    // Prefetch registers
    ula_video_pkg::vram_byte_u attr_pre;

    assign x_off = hcount - x_origin;
    assign y_off = vcount - y_origin;
    assign col   = x_off[8:4];              // 16 clocks per cell
    assign py    = y_off[8:1];              // Lines are doubled

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slot sequencer on hcount[3:0]
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            vram_addr <= '0;
            bits_pre  <= '0;
            attr_pre  <= '0;
            cell_bits <= '0;
            cell_attr <= '0;
        end else begin
            case (hcount[3:0])
                4'd10: begin
                    // Swizzled bitmap address: third, row in char, char row, column
                    vram_addr <= {py[7:6], py[2:0], py[5:3], col};
                end
                4'd12: begin
                    bits_pre.bits <= vram_rdata;                // Bitmap back from slot 10
                    vram_addr     <= {3'b110, py[7:3], col};    // Attribute map at 0x1800
                end
                4'd14: attr_pre.attr <= ula_video_pkg::attr_t'(vram_rdata);
                4'd15: begin
                    // Hand over at the last clock of the cell
                    cell_bits <= bits_pre;
                    cell_attr <= attr_pre;
                end
                default: ;                                      // Idle slots
            endcase
        end
    end

endmodule

/* design/ula_video.sv */
`timescale 1ns/1ps

module ula_video #(
    parameter int FLASH_LOG2 = 4                    // 16 frames on, 16 off
) (
    input  logic                      clk_pix,      // 25.175 MHz
    input  logic                      arst_n,
    input  logic [2:0]                border,       // Border colour, no bright
    input  logic                      cpu_we,
    input  ula_video_pkg::vram_addr_t cpu_addr,
    input  logic [7:0]                cpu_data,
    output logic [3:0]                vga_r,
    output logic [3:0]                vga_g,
    output logic [3:0]                vga_b,
    output logic                      vga_hs,
    output logic                      vga_vs,
    output logic                      vs_nintr
);

    ula_video_pkg::hcount_t    hcount;
    ula_video_pkg::vcount_t    vcount;
    logic                      disp_en;
    logic                      scr_en;
    logic                      flash_phase;
    ula_video_pkg::vram_addr_t vram_addr;
    logic [7:0]                vram_rdata;
    ula_video_pkg::vram_byte_u cell_bits;
    ula_video_pkg::vram_byte_u cell_attr;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster timing
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    video_timing #(.FLASH_LOG2(FLASH_LOG2)) video_timing_inst (
        .clk_pix, .arst_n, .hcount, .vcount, .disp_en, .scr_en,
        .flash_phase, .vga_hs, .vga_vs, .vs_nintr
    );

    // Cell prefetch from RAM
    screen_fetch screen_fetch_inst (
        .clk_pix, .arst_n, .hcount, .vcount, .vram_addr, .vram_rdata,
        .cell_bits, .cell_attr
    );

    video_ram video_ram_inst (
        .clk_pix, .cpu_we, .cpu_addr, .cpu_data, .vram_addr, .vram_rdata
    );

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Colour out
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    pixel_render #(.FLASH_LOG2(FLASH_LOG2)) pixel_render_inst (
        .hcount, .disp_en, .scr_en, .flash_phase, .border,
        .cell_bits, .cell_attr, .vga_r, .vga_g, .vga_b
    );

endmodule

/* design/ula_video_pkg.sv */
package ula_video_pkg;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 640x480 raster at 25.175 MHz
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int h_total      = 800;  // Clocks per line
    localparam int h_sync       = 96;   // HS low while hcount below this
    localparam int h_disp_start = 144;  // First visible clock
    localparam int h_disp_end   = 784;  // One past last visible clock
    localparam int h_scr_start  = 208;  // Left edge of the 512 wide screen
    localparam int h_scr_end    = 720;

    localparam int v_total      = 525;  // Lines per frame
    localparam int v_sync       = 2;
    localparam int v_disp_start = 35;   // Also the interrupt line
    localparam int v_disp_end   = 515;
    localparam int v_scr_start  = 83;   // Top of the 384 line screen
    localparam int v_scr_end    = 467;

    typedef logic [9:0]  hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [12:0] vram_addr_t;   // 8 KB of video RAM
    typedef logic [11:0] rgb_t;         // R in [11:8], G in [7:4], B in [3:0]
    typedef logic [3:0]  cindex_t;      // {bright, grb}

    // Spectrum attribute byte
    typedef struct packed {
        logic       flash;
        logic       bright;
        logic [2:0] paper;
        logic [2:0] ink;
    } attr_t;

    // A RAM byte is a bitmap row in one fetch slot and an attribute in the other
    typedef union packed {
        logic [7:0] bits;
        attr_t      attr;
    } vram_byte_u;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Colour lookup
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit 0 blue, bit 1 red, bit 2 green; bright lifts D to F
    // Black stays 000 in both halves since no gun is on
    function automatic rgb_t palette(input cindex_t c);
        logic [3:0] lvl;
        rgb_t       rgb;
        lvl = c[3] ? 4'hF : 4'hD;
        rgb[11:8] = c[1] ? lvl : 4'h0;  // Red
        rgb[7:4]  = c[2] ? lvl : 4'h0;  // Green
        rgb[3:0]  = c[0] ? lvl : 4'h0;  // Blue
        return rgb;
    endfunction

endpackage

/* design/video_ram.sv */
`timescale 1ns/1ps

module video_ram (
    input  logic                      clk_pix,
    input  logic                      cpu_we,       // Write strobe, one byte per clock
    input  ula_video_pkg::vram_addr_t cpu_addr,
    input  logic [7:0]                cpu_data,
    input  ula_video_pkg::vram_addr_t vram_addr,    // Video read address
    output logic [7:0]                vram_rdata    // Valid one clock later
);

    localparam int depth = 2 ** $bits(ula_video_pkg::vram_addr_t);

    logic [7:0] mem [depth];    // Bitmap 0x0000..0x17FF, attributes 0x1800..0x1AFF

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU write port
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_pix) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_data;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Video read port
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read before write on a shared address, the old byte comes out
    always_ff @(posedge clk_pix) begin
        vram_rdata <= mem[vram_addr];
    end

endmodule

/* design/video_timing.sv */
`timescale 1ns/1ps

module video_timing #(
    parameter int FLASH_LOG2 = 4            // Frame counter bit driving flash
) (
    input  logic                   clk_pix,
    input  logic                   arst_n,
    output ula_video_pkg::hcount_t hcount,
    output ula_video_pkg::vcount_t vcount,
    output logic                   disp_en,     // Visible 640x480 area
    output logic                   scr_en,      // 512x384 screen area
    output logic                   flash_phase,
    output logic                   vga_hs,
    output logic                   vga_vs,
    output logic                   vs_nintr     // Retrace interrupt, active low
);

    // A negative setting turns flash off downstream; keep the counter legal
    localparam int flash_bit = (FLASH_LOG2 < 0) ? 0 : FLASH_LOG2;

    localparam ula_video_pkg::hcount_t h_last = ula_video_pkg::hcount_t'(
        ula_video_pkg::h_total - 1);
    localparam ula_video_pkg::vcount_t v_last = ula_video_pkg::vcount_t'(
        ula_video_pkg::v_total - 1);

    logic [flash_bit:0] frame;              // Wraps freely

    logic line_end;
    logic frame_end;

    assign line_end  = (hcount == h_last);
    assign frame_end = line_end && (vcount == v_last);

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster and frame counters
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hcount <= '0;
            vcount <= '0;
            frame  <= '0;
        end else begin
            hcount <= line_end ? '0 : hcount + 1'b1;   // One clock per pixel
            if (line_end) begin
                vcount <= (vcount == v_last) ? '0 : vcount + 1'b1;
            end
            if (frame_end) begin
                frame <= frame + 1'b1;
            end
        end
    end

    assign flash_phase = frame[flash_bit];

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sync, interrupt and window decode
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Both syncs start low out of reset, which is the first pulse
    assign vga_hs = (hcount >= ula_video_pkg::h_sync);
    assign vga_vs = (vcount >= ula_video_pkg::v_sync);

    // Low for the left blank part of the first visible line
    assign vs_nintr = !((vcount == ula_video_pkg::v_disp_start)
                        && (hcount < ula_video_pkg::h_disp_start));

    assign disp_en = (hcount >= ula_video_pkg::h_disp_start)
                  && (hcount <  ula_video_pkg::h_disp_end)
                  && (vcount >= ula_video_pkg::v_disp_start)
                  && (vcount <  ula_video_pkg::v_disp_end);

    assign scr_en  = (hcount >= ula_video_pkg::h_scr_start)
                  && (hcount <  ula_video_pkg::h_scr_end)
                  && (vcount >= ula_video_pkg::v_scr_start)
                  && (vcount <  ula_video_pkg::v_scr_end);

endmodule

/* files.f */
+incdir+bench
design/ula_video_pkg.sv
design/video_timing.sv
design/screen_fetch.sv
design/video_ram.sv
design/pixel_render.sv
design/ula_video.sv
bench/ula_video_tb.sv
